// ==== bpcuPkg.sv ====
// Shared opcodes, condition codes, APB address map and bus/pipeline types for the front end
`default_nettype none

package bpcuPkg;

   // Instruction memory geometry, word addressed
   localparam int progAddrW = 8;
   localparam int progDepth = 1 << progAddrW;

   // Branch class and halt opcodes, MicroBlaze major opcode field
   localparam logic [5:0] opBr   = 6'o46;
   localparam logic [5:0] opBrI  = 6'o56;
   localparam logic [5:0] opBcc  = 6'o47;
   localparam logic [5:0] opBccI = 6'o57;
   localparam logic [5:0] opRtd  = 6'o55;
   localparam logic [5:0] opHalt = 6'o77;

   // BCC condition codes carried in rd[2:0]
   // Codes 6 and 7 are never taken
   localparam logic [2:0] ccEq = 3'd0;
   localparam logic [2:0] ccNe = 3'd1;
   localparam logic [2:0] ccLt = 3'd2;
   localparam logic [2:0] ccLe = 3'd3;
   localparam logic [2:0] ccGt = 3'd4;
   localparam logic [2:0] ccGe = 3'd5;

   // APB byte address map
   localparam logic [15:0] addrMemBase = 16'h0000;
   localparam logic [15:0] addrRegBase = 16'h1000;
   localparam logic [15:0] addrCtrl    = 16'h2000;
   localparam logic [15:0] addrCount   = 16'h2004;

   // Register form, second source in rb
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] unused;
   } instrTypeA;

   // Immediate form, 16-bit signed offset
   typedef struct packed {
      logic [5:0]         opcode;
      logic [4:0]         rd;
      logic [4:0]         ra;
      logic signed [15:0] imm;
   } instrTypeB;

   // Opcode bit 3 picks the view
   typedef union packed {
      instrTypeA typeA;
      instrTypeB typeB;
   } instrWord;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [15:0] paddr;
      logic [31:0] pwdata;
   } apbReq;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apbRsp;

   // Instruction sitting in execute, tagged with its word address
   typedef struct packed {
      logic                 valid;
      logic [progAddrW-1:0] pc;
      instrWord             word;
   } execInstr;

   typedef struct packed {
      logic [progAddrW-1:0] pc;
      logic [5:0]           opcode;
      logic                 taken;
      logic                 delayed;
      logic [progAddrW-1:0] nextPc;
   } traceEntry;

endpackage

`default_nettype wire

// ==== progMem.sv ====
// Instruction memory, written by the host over APB and read by fetch one cycle after the address
`default_nettype none
`timescale 1ns/1ps

module progMem (
   input  wire                              gclk,
   input  wire                              wrEn,
   input  wire  [bpcuPkg::progAddrW-1:0]    wrAddr,
   input  wire  [31:0]                      wrData,
   input  wire  [bpcuPkg::progAddrW-1:0]    rdAddr,
   output bpcuPkg::instrWord                rdData
);

   // Word storage, no reset, contents undefined until loaded
   logic [31:0] mem [0:bpcuPkg::progDepth-1];

   // Load port
   // Host only writes while the core is stopped
   always_ff @(posedge gclk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
   end

   // Fetch port
   // Registered read, word shows up the cycle after rdAddr
   always_ff @(posedge gclk) begin
      rdData <= mem[rdAddr];
   end

endmodule

`default_nettype wire

// ==== regFile.sv ====
// General register file, loaded by the host, read by the branch unit and by APB readback
`default_nettype none
`timescale 1ns/1ps

module regFile (
   input  wire         gclk,
   input  wire         wrEn,
   input  wire  [4:0]  wrAddr,
   input  wire  [31:0] wrData,
   input  wire  [4:0]  rdAddrA,
   input  wire  [4:0]  rdAddrB,
   input  wire  [4:0]  rdAddrC,
   output logic [31:0] rdDataA,
   output logic [31:0] rdDataB,
   output logic [31:0] rdDataC
);

   // 32 architectural registers
   logic [31:0] regs [0:31];

   // Single write port from the host
   always_ff @(posedge gclk) begin
      if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Combinational reads
   // r0 is hardwired to zero whatever was written there
   // A is the branch condition / RTD base, B the BR/BCC offset
   assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
   assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

   // C serves APB readback
   assign rdDataC = (rdAddrC == 5'd0) ? 32'd0 : regs[rdAddrC];

endmodule

`default_nettype wire

// ==== hostPort.sv ====
// APB slave that loads memory and registers, owns run/halted and counts retired instructions
`default_nettype none
`timescale 1ns/1ps

module hostPort (
   input  wire                              gclk,
   input  wire                              grst,
   input  wire  bpcuPkg::apbReq             apb,
   output bpcuPkg::apbRsp                   apbRsp,
   output logic                             memWrEn,
   output logic [bpcuPkg::progAddrW-1:0]    memWrAddr,
   output logic [31:0]                      memWrData,
   output logic                             regWrEn,
   output logic [4:0]                       regWrAddr,
   output logic [31:0]                      regWrData,
   output logic [4:0]                       regRdAddr,
   input  wire  [31:0]                      regRdData,
   output logic                             run,
   output logic                             start,
   input  wire                              halt,
   input  wire                              retire
);

   logic        access;
   logic        wrAcc;
   logic        memHit;
   logic        regHit;
   logic        ctrlHit;
   logic        countHit;
   logic        halted;
   logic [31:0] retired;

   // Access phase, zero wait states
   assign access = apb.psel & apb.penable;
   assign wrAcc  = access & apb.pwrite;

   // Address decode, 1 KB of program words, 128 B of registers
   assign memHit   = apb.paddr[15:10] == bpcuPkg::addrMemBase[15:10];
   assign regHit   = apb.paddr[15:7] == bpcuPkg::addrRegBase[15:7];
   assign ctrlHit  = apb.paddr == bpcuPkg::addrCtrl;
   assign countHit = apb.paddr == bpcuPkg::addrCount;

   // Loads are only accepted while stopped
   assign memWrEn   = wrAcc & memHit & ~run;
   assign memWrAddr = apb.paddr[bpcuPkg::progAddrW+1:2];
   assign memWrData = apb.pwdata;
   assign regWrEn   = wrAcc & regHit & ~run;
   assign regWrAddr = apb.paddr[6:2];
   assign regWrData = apb.pwdata;
   assign regRdAddr = apb.paddr[6:2];

   // One-cycle start pulse, fetch PC goes to 0 on this edge
   assign start = wrAcc & ctrlHit & apb.pwdata[0];

   always_ff @(posedge gclk) begin
      if (grst) begin
         run     <= 1'b0;
         halted  <= 1'b0;
         retired <= 32'd0;
      end else begin
         // Host write beats a halt in the same cycle
         if (wrAcc && ctrlHit) begin
            run <= apb.pwdata[0];
            if (apb.pwdata[0]) begin
               halted <= 1'b0;
            end
         end else if (halt) begin
            run    <= 1'b0;
            halted <= 1'b1;
         end
         if (start) begin
            retired <= 32'd0;
         end else if (retire) begin
            retired <= retired + 32'd1;
         end
      end
   end

   // Read data and error response
   always_comb begin
      apbRsp.pready  = 1'b1;
      apbRsp.pslverr = 1'b0;
      apbRsp.prdata  = 32'd0;
      if (memHit) begin
         // Program memory is write only, and locked while running
         apbRsp.pslverr = access & (~apb.pwrite | run);
      end else if (regHit) begin
         apbRsp.prdata  = regRdData;
         apbRsp.pslverr = wrAcc & run;
      end else if (ctrlHit) begin
         apbRsp.prdata = {30'd0, halted, run};
      end else if (countHit) begin
         apbRsp.prdata = retired;
      end else begin
         apbRsp.pslverr = access;
      end
   end

endmodule

`default_nettype wire

// ==== fetchDecode.sv ====
// Fetch PC and the fetch-to-execute hand-off, tagging each returned word with its address
`default_nettype none
`timescale 1ns/1ps

module fetchDecode (
   input  wire                              gclk,
   input  wire                              grst,
   input  wire                              run,
   input  wire                              start,
   input  wire                              redirect,
   input  wire  [bpcuPkg::progAddrW-1:0]    redirectPc,
   input  wire                              squash,
   output logic [bpcuPkg::progAddrW-1:0]    fetchAddr,
   input  wire  bpcuPkg::instrWord          fetchWord,
   output bpcuPkg::execInstr                exec
);

   // Address and validity of the word now coming out of memory
   logic [bpcuPkg::progAddrW-1:0] tagPc;
   logic                          tagValid;

   // Fetch PC
   // Start wins, then a taken branch, else sequential
   // Holds while stopped
   always_ff @(posedge gclk) begin
      if (grst) begin
         fetchAddr <= '0;
      end else if (start) begin
         fetchAddr <= '0;
      end else if (run) begin
         fetchAddr <= redirect ? redirectPc : fetchAddr + 1'b1;
      end
   end

   // Tag tracks the memory read latency
   // A fetch issued while stopped, during start or under squash is dead
   always_ff @(posedge gclk) begin
      if (grst) begin
         tagValid <= 1'b0;
      end else begin
         tagValid <= run & ~start & ~squash;
      end
   end

   always_ff @(posedge gclk) begin
      tagPc <= fetchAddr;
   end

   // Execute stage sees the memory output register directly
   always_comb begin
      exec.valid = tagValid & run;
      exec.pc    = tagPc;
      exec.word  = fetchWord;
   end

endmodule

`default_nettype wire

// ==== branchPcUnit.sv ====
// Branch resolution in execute, next-PC selection, delay-slot squash and the retire trace
`default_nettype none
`timescale 1ns/1ps

module branchPcUnit (
   input  wire                              gclk,
   input  wire                              grst,
   input  wire                              run,
   input  wire  bpcuPkg::execInstr          exec,
   output logic [4:0]                       regRdAddrA,
   output logic [4:0]                       regRdAddrB,
   input  wire  [31:0]                      regA,
   input  wire  [31:0]                      regB,
   output logic                             redirect,
   output logic [bpcuPkg::progAddrW-1:0]    redirectPc,
   output logic                             squash,
   output logic                             halt,
   output logic                             retire,
   output logic                             traceValid,
   output bpcuPkg::traceEntry               trace
);

   bpcuPkg::instrWord             word;
   logic [5:0]                    opcode;
   logic                          active;
   logic                          isBr;
   logic                          isBcc;
   logic                          isRtd;
   logic                          isHalt;
   logic                          regAZero;
   logic                          regANeg;
   logic                          ccTaken;
   logic                          taken;
   logic                          delayed;
   logic [31:0]                   base;
   logic [31:0]                   offset;
   logic [31:0]                   targetSum;
   logic [bpcuPkg::progAddrW-1:0] target;
   logic [bpcuPkg::progAddrW-1:0] seqPc;

   assign word   = exec.word;
   assign opcode = word.typeA.opcode;

   // Slot behind a retired HALT is still in flight, keep it out
   assign active = exec.valid & run & ~halt;

   // Branch class decode
   assign isBr   = (opcode == bpcuPkg::opBr) | (opcode == bpcuPkg::opBrI);
   assign isBcc  = (opcode == bpcuPkg::opBcc) | (opcode == bpcuPkg::opBccI);
   assign isRtd  = opcode == bpcuPkg::opRtd;
   assign isHalt = opcode == bpcuPkg::opHalt;

   // Register fields sit at the same place in both views
   assign regRdAddrA = word.typeA.ra;
   assign regRdAddrB = word.typeA.rb;

   // regA tested signed against zero
   assign regAZero = regA == 32'd0;
   assign regANeg  = regA[31];

   always_comb begin
      case (word.typeA.rd[2:0])
         bpcuPkg::ccEq: ccTaken = regAZero;
         bpcuPkg::ccNe: ccTaken = ~regAZero;
         bpcuPkg::ccLt: ccTaken = regANeg;
         bpcuPkg::ccLe: ccTaken = regANeg | regAZero;
         bpcuPkg::ccGt: ccTaken = ~(regANeg | regAZero);
         bpcuPkg::ccGe: ccTaken = ~regANeg;
         default:       ccTaken = 1'b0;
      endcase
   end

   assign taken = isBr | isRtd | (isBcc & ccTaken);

   // Delay flag: ra[4] for BR, rd[4] for BCC, RTD always delays
   assign delayed = (isBr & word.typeA.ra[4]) | (isBcc & word.typeA.rd[4]) | isRtd;

   // Target base is the branch PC, or regA for RTD
   assign base = isRtd ? regA : {{(32 - bpcuPkg::progAddrW){1'b0}}, exec.pc};

   // Opcode bit 3 selects immediate form over register form
   assign offset = opcode[3] ? {{16{word.typeB.imm[15]}}, word.typeB.imm} : regB;

   // Wraps within the memory depth
   assign targetSum = base + offset;
   assign target    = targetSum[bpcuPkg::progAddrW-1:0];
   assign seqPc     = exec.pc + 1'b1;

   // Redirect fetch now, and kill the slot unless it is a delay slot
   assign redirect   = active & taken;
   assign redirectPc = target;
   assign squash     = redirect & ~delayed;

   // Trace and halt are registered, one cycle after execute
   always_ff @(posedge gclk) begin
      if (grst) begin
         traceValid <= 1'b0;
         halt       <= 1'b0;
      end else begin
         traceValid <= active;
         halt       <= active & isHalt;
      end
   end

   // Next in program order is the target only when nothing sits in a delay slot
   always_ff @(posedge gclk) begin
      trace.pc      <= exec.pc;
      trace.opcode  <= opcode;
      trace.taken   <= taken;
      trace.delayed <= delayed;
      trace.nextPc  <= (taken & ~delayed) ? target : seqPc;
   end

   // Every traced instruction retires
   assign retire = traceValid;

endmodule

`default_nettype wire

// ==== bpcuTop.sv ====
// Top level of the branch and PC front end, joining host port, memories, fetch and branch unit
`default_nettype none
`timescale 1ns/1ps

module bpcuTop (
   input  wire                  gclk,
   input  wire                  grst,
   input  wire  bpcuPkg::apbReq apb,
   output bpcuPkg::apbRsp       apbRsp,
   output logic                 traceValid,
   output bpcuPkg::traceEntry   trace
);

   // Host load paths
   logic                          memWrEn;
   logic [bpcuPkg::progAddrW-1:0] memWrAddr;
   logic [31:0]                   memWrData;
   logic                          regWrEn;
   logic [4:0]                    regWrAddr;
   logic [31:0]                   regWrData;
   logic [4:0]                    regRdAddr;
   logic [31:0]                   regRdData;

   // Control handshake between host port and core
   logic                          run;
   logic                          start;
   logic                          halt;
   logic                          retire;

   // Fetch and execute
   logic [bpcuPkg::progAddrW-1:0] fetchAddr;
   bpcuPkg::instrWord             fetchWord;
   bpcuPkg::execInstr             exec;
   logic [4:0]                    regRdAddrA;
   logic [4:0]                    regRdAddrB;
   logic [31:0]                   regA;
   logic [31:0]                   regB;
   logic                          redirect;
   logic [bpcuPkg::progAddrW-1:0] redirectPc;
   logic                          squash;

   hostPort i_hostPort (
      .gclk(gclk), .grst(grst), .apb(apb), .apbRsp(apbRsp),
      .memWrEn(memWrEn), .memWrAddr(memWrAddr), .memWrData(memWrData),
      .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
      .regRdAddr(regRdAddr), .regRdData(regRdData),
      .run(run), .start(start), .halt(halt), .retire(retire)
   );

   progMem i_progMem (
      .gclk(gclk), .wrEn(memWrEn), .wrAddr(memWrAddr), .wrData(memWrData),
      .rdAddr(fetchAddr), .rdData(fetchWord)
   );

   regFile i_regFile (
      .gclk(gclk), .wrEn(regWrEn), .wrAddr(regWrAddr), .wrData(regWrData),
      .rdAddrA(regRdAddrA), .rdAddrB(regRdAddrB), .rdAddrC(regRdAddr),
      .rdDataA(regA), .rdDataB(regB), .rdDataC(regRdData)
   );

   fetchDecode i_fetchDecode (
      .gclk(gclk), .grst(grst), .run(run), .start(start),
      .redirect(redirect), .redirectPc(redirectPc), .squash(squash),
      .fetchAddr(fetchAddr), .fetchWord(fetchWord), .exec(exec)
   );

   branchPcUnit i_branchPcUnit (
      .gclk(gclk), .grst(grst), .run(run), .exec(exec),
      .regRdAddrA(regRdAddrA), .regRdAddrB(regRdAddrB), .regA(regA), .regB(regB),
      .redirect(redirect), .redirectPc(redirectPc), .squash(squash),
      .halt(halt), .retire(retire), .traceValid(traceValid), .trace(trace)
   );

endmodule

`default_nettype wire

// ==== bpcu_properties.sv ====
// Concurrent checks on the branch unit, bound into every branchPcUnit instance
`default_nettype none
`timescale 1ns/1ps

module bpcuProperties (
   input wire               gclk,
   input wire               grst,
   input wire               run,
   input wire               traceValid,
   input wire               squash,
   input wire               redirect,
   input wire bpcuPkg::execInstr exec
);

   // Trace stays quiet in reset and one cycle after a stopped cycle
   traceInReset: assert property (@(posedge gclk) grst |=> !traceValid)
      else $error("trace valid right after reset");

   traceWhileStopped: assert property (@(posedge gclk) disable iff (grst) !$past(run) |-> !traceValid)
      else $error("trace valid while the core was stopped");

   // Squash only comes with a taken branch
   squashNeedsRedirect: assert property (@(posedge gclk) disable iff (grst) squash |-> redirect)
      else $error("squash without redirect");

   // A redirect needs a live instruction in execute
   redirectNeedsExec: assert property (@(posedge gclk) disable iff (grst) redirect |-> exec.valid)
      else $error("redirect without a valid instruction");

endmodule

bind branchPcUnit bpcuProperties i_bpcuProperties (
   .gclk(gclk), .grst(grst), .run(run), .traceValid(traceValid),
   .squash(squash), .redirect(redirect), .exec(exec)
);

`default_nettype wire

// ==== bpcuTb.sv ====
// Testbench for the branch and PC front end that loads programs over APB and checks the trace
`default_nettype none
`timescale 1ns/1ps

module bpcuTb;

   logic               gclk;
   logic               grst;
   bpcuPkg::apbReq     apb;
   bpcuPkg::apbRsp     apbRsp;
   logic               traceValid;
   bpcuPkg::traceEntry trace;

   // Program image, register values and expected trace
   logic [31:0]        progImg [256];
   logic [31:0]        regImg [32];
   bpcuPkg::traceEntry expQ [$];
   int                 expLen;
   int                 errors;
   string              testName;

   bpcuTop i_bpcuTop (
      .gclk(gclk), .grst(grst), .apb(apb), .apbRsp(apbRsp),
      .traceValid(traceValid), .trace(trace)
   );

   initial begin
      gclk = 1'b0;
      forever #50 gclk = ~gclk;
   end

   // Watchdog sized for 6 tests of 2000 cycles
   initial begin
      #(6 * 2000 * 100);
      $display("watchdog expired, simulation did not finish in time");
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic logic [31:0] encA(logic [5:0] op, logic [4:0] rd, logic [4:0] ra,
                                        logic [4:0] rb);
      return {op, rd, ra, rb, 11'd0};
   endfunction

   function automatic logic [31:0] encB(logic [5:0] op, logic [4:0] rd, logic [4:0] ra, int imm);
      return {op, rd, ra, imm[15:0]};
   endfunction

   // No-op carries its own address in the low byte
   function automatic logic [31:0] nopWord(int a);
      return {6'o00, 18'd0, a[7:0]};
   endfunction

   function automatic logic [31:0] randVal();
      case ($urandom_range(0, 3))
         0: return 32'd0;
         1: return -32'($urandom_range(1, 20));
         2: return 32'($urandom_range(1, 20));
         default: return $urandom;
      endcase
   endfunction

   // BCC comparison of the tested register against zero
   function automatic bit condHolds(logic [2:0] cc, logic [31:0] v);
      case (cc)
         3'd0: return v == 32'd0;
         3'd1: return v != 32'd0;
         3'd2: return $signed(v) < 0;
         3'd3: return $signed(v) <= 0;
         3'd4: return $signed(v) > 0;
         3'd5: return $signed(v) >= 0;
         default: return 1'b0;
      endcase
   endfunction

   // Reference model stepping the fetch slot and the execute slot into expQ
   // Returns 0 when no HALT is reached within 500 instructions
   function automatic bit refRun(input logic [31:0] img [256], input logic [31:0] rv [32]);
      logic [7:0]         fetchPc;
      logic [7:0]         slotPc;
      logic [7:0]         tgt;
      bit                 slotValid;
      bit                 redirect;
      bit                 kill;
      bit                 isBr;
      bit                 isBcc;
      bit                 isRtd;
      bit                 tk;
      bit                 dl;
      logic [31:0]        w;
      logic [31:0]        va;
      logic [31:0]        vb;
      logic [31:0]        off;
      logic [31:0]        sum;
      logic [5:0]         op;
      bpcuPkg::traceEntry e;
      int                 n;
      fetchPc = 8'd0;
      slotPc = 8'd0;
      slotValid = 1'b0;
      n = 0;
      expQ.delete();
      for (int step = 0; step < 1200; step++) begin
         redirect = 1'b0;
         kill = 1'b0;
         tgt = 8'd0;
         if (slotValid) begin
            w = img[slotPc];
            op = w[31:26];
            va = (w[20:16] == 5'd0) ? 32'd0 : rv[w[20:16]];
            vb = (w[15:11] == 5'd0) ? 32'd0 : rv[w[15:11]];
            isBr = (op == bpcuPkg::opBr) || (op == bpcuPkg::opBrI);
            isBcc = (op == bpcuPkg::opBcc) || (op == bpcuPkg::opBccI);
            isRtd = op == bpcuPkg::opRtd;
            tk = isBr || isRtd || (isBcc && condHolds(w[23:21], va));
            // Delay flag in ra[4] for BR and in rd[4] for BCC
            dl = (isBr && w[20]) || (isBcc && w[25]) || isRtd;
            off = op[3] ? {{16{w[15]}}, w[15:0]} : vb;
            sum = (isRtd ? va : {24'd0, slotPc}) + off;
            tgt = sum[7:0];
            e.pc = slotPc;
            e.opcode = op;
            e.taken = tk;
            e.delayed = dl;
            e.nextPc = (tk && !dl) ? tgt : slotPc + 8'd1;
            expQ.push_back(e);
            n++;
            if (op == bpcuPkg::opHalt) return 1'b1;
            if (n >= 500) return 1'b0;
            redirect = tk;
            kill = tk && !dl;
         end
         // Word already fetched moves to execute unless squashed
         slotValid = !kill;
         slotPc = fetchPc;
         fetchPc = redirect ? tgt : fetchPc + 8'd1;
      end
      return 1'b0;
   endfunction

   // Each trace entry is compared against the queue mid-cycle
   always @(negedge gclk) begin
      bpcuPkg::traceEntry e;
      if (!grst && traceValid) begin
         if (expQ.size() == 0) begin
            errors++;
            $display("%s: trace entry at pc %0d was not expected", testName, trace.pc);
         end else begin
            e = expQ.pop_front();
            if (trace.pc !== e.pc) begin
               errors++;
               $display("mismatch %s pc: expected %0d actual %0d", testName, e.pc, trace.pc);
            end
            if (trace.opcode !== e.opcode) begin
               errors++;
               $display("mismatch %s opcode: expected %o actual %o", testName, e.opcode,
                        trace.opcode);
            end
            if (trace.taken !== e.taken) begin
               errors++;
               $display("mismatch %s taken at pc %0d: expected %b actual %b", testName, e.pc,
                        e.taken, trace.taken);
            end
            if (trace.delayed !== e.delayed) begin
               errors++;
               $display("mismatch %s delayed at pc %0d: expected %b actual %b", testName, e.pc,
                        e.delayed, trace.delayed);
            end
            if (trace.nextPc !== e.nextPc) begin
               errors++;
               $display("mismatch %s nextPc at pc %0d: expected %0d actual %0d", testName,
                        e.pc, e.nextPc, trace.nextPc);
            end
         end
      end
   end

   // One APB transfer that starts and ends 1 ns after a rising edge
   task automatic apbXfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                          output logic [31:0] rd, output logic err);
      apb.psel = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite = wr;
      apb.paddr = addr;
      apb.pwdata = data;
      @(posedge gclk);
      #1;
      apb.penable = 1'b1;
      @(negedge gclk);
      rd = apbRsp.prdata;
      err = apbRsp.pslverr;
      if (apbRsp.pready !== 1'b1) begin
         errors++;
         $display("mismatch %s pready at %h: expected 1 actual %b", testName, addr,
                  apbRsp.pready);
      end
      @(posedge gclk);
      #1;
      apb.psel = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic apbWrite(input logic [15:0] addr, input logic [31:0] data, input logic expErr);
      logic [31:0] rd;
      logic        err;
      apbXfer(1'b1, addr, data, rd, err);
      if (err !== expErr) begin
         errors++;
         $display("mismatch %s pslverr on write %h: expected %b actual %b", testName, addr,
                  expErr, err);
      end
   endtask

   task automatic apbRead(input logic [15:0] addr, output logic [31:0] data,
                          input logic expErr);
      logic err;
      apbXfer(1'b0, addr, 32'd0, data, err);
      if (err !== expErr) begin
         errors++;
         $display("mismatch %s pslverr on read %h: expected %b actual %b", testName, addr,
                  expErr, err);
      end
   endtask

   task automatic readCheck(input logic [15:0] addr, input logic [31:0] expVal);
      logic [31:0] d;
      apbRead(addr, d, 1'b0);
      if (d !== expVal) begin
         errors++;
         $display("mismatch %s read %h: expected %h actual %h", testName, addr, expVal, d);
      end
   endtask

   // Program lives in words 0 to 31 and the rest keeps the HALT fill
   task automatic loadProgram();
      for (int a = 0; a < 32; a++) begin
         apbWrite(16'(a * 4), progImg[a], 1'b0);
      end
   endtask

   task automatic loadRegs();
      for (int r = 1; r < 32; r++) begin
         apbWrite(bpcuPkg::addrRegBase + 16'(r * 4), regImg[r], 1'b0);
      end
   endtask

   task automatic startRun();
      if (!refRun(progImg, regImg)) begin
         errors++;
         $display("%s: reference run reached no HALT", testName);
      end
      expLen = expQ.size();
      apbWrite(bpcuPkg::addrCtrl, 32'd1, 1'b0);
   endtask

   // Poll for halted and then check queue, control and count
   task automatic finishRun();
      logic [31:0] d;
      int          polls;
      polls = 0;
      do begin
         apbRead(bpcuPkg::addrCtrl, d, 1'b0);
         polls++;
      end while (!d[1] && polls < 600);
      if (!d[1]) begin
         errors++;
         $display("%s: core did not halt within 1200 cycles", testName);
      end
      repeat (3) @(posedge gclk);
      #1;
      if (expQ.size() != 0) begin
         errors++;
         $display("%s: %0d expected trace entries never arrived", testName, expQ.size());
      end
      readCheck(bpcuPkg::addrCtrl, 32'd2);
      readCheck(bpcuPkg::addrCount, 32'(expLen));
   endtask

   task automatic clearProgram();
      for (int a = 0; a < 32; a++) begin
         progImg[a] = nopWord(a);
      end
   endtask

   // Forward and backward BR/BRI with and without delay
   task automatic buildJumpProgram();
      clearProgram();
      progImg[1] = encB(bpcuPkg::opBrI, 5'd0, 5'd0, 4);
      progImg[5] = encB(bpcuPkg::opBrI, 5'd0, 5'd16, 5);
      progImg[10] = encA(bpcuPkg::opBr, 5'd0, 5'd16, 5'd1);
      progImg[16] = encA(bpcuPkg::opBr, 5'd0, 5'd0, 5'd2);
      progImg[13] = encB(bpcuPkg::opBrI, 5'd0, 5'd0, 7);
      progImg[20] = {bpcuPkg::opHalt, 26'd0};
      regImg[1] = 32'd6;
      regImg[2] = -32'd3;
   endtask

   initial begin
      logic [31:0] d;
      int          tries;
      void'($urandom(32'hce03dd65));
      errors = 0;
      testName = "reset";
      grst = 1'b1;
      apb = '0;
      for (int a = 0; a < 256; a++) begin
         progImg[a] = {bpcuPkg::opHalt, 18'd0, a[7:0]};
      end
      for (int r = 0; r < 32; r++) begin
         regImg[r] = 32'd0;
      end
      repeat (5) @(posedge gclk);
      #1;
      grst = 1'b0;

      // Test 1 covers idle state, register readback and error responses
      testName = "resetIdle";
      readCheck(bpcuPkg::addrCtrl, 32'd0);
      readCheck(bpcuPkg::addrCount, 32'd0);
      repeat (50) @(posedge gclk);
      #1;
      for (int r = 1; r < 32; r++) begin
         regImg[r] = randVal();
      end
      loadRegs();
      apbWrite(bpcuPkg::addrRegBase, 32'hffff, 1'b0);
      readCheck(bpcuPkg::addrRegBase, 32'd0);
      for (int r = 1; r < 32; r++) begin
         readCheck(bpcuPkg::addrRegBase + 16'(r * 4), regImg[r]);
      end
      apbRead(bpcuPkg::addrMemBase + 16'd8, d, 1'b1);
      apbRead(16'h3000, d, 1'b1);
      apbWrite(16'h3004, 32'd1, 1'b1);
      for (int a = 0; a < 256; a++) begin
         apbWrite(16'(a * 4), progImg[a], 1'b0);
      end

      // Test 2 runs the unconditional branches
      testName = "uncondBranch";
      buildJumpProgram();
      loadProgram();
      loadRegs();
      startRun();
      finishRun();

      // Test 3 runs all condition codes in both forms with delay on odd slots
      testName = "condBranch";
      clearProgram();
      for (int k = 0; k < 16; k++) begin
         progImg[2 * k] = encB((k < 8) ? bpcuPkg::opBcc : bpcuPkg::opBccI,
                               {k[0], 1'b0, k[2:0]}, 5'((k % 7) + 1), 2);
         if (k < 8) begin
            progImg[2 * k] = encA(bpcuPkg::opBcc, {k[0], 1'b0, k[2:0]}, 5'((k % 7) + 1),
                                  5'd8);
         end
      end
      regImg[8] = 32'd2;
      for (int pass = 0; pass < 3; pass++) begin
         for (int r = 1; r < 8; r++) begin
            regImg[r] = (pass == 0) ? ((r % 3 == 0) ? 32'd0 : ((r % 3 == 1) ? -32'd1 : 32'd5))
                                    : randVal();
         end
         loadProgram();
         loadRegs();
         startRun();
         finishRun();
      end

      // Test 4 checks that RTD always runs its delay slot and HALT ends the run
      testName = "returnHalt";
      clearProgram();
      regImg[3] = 32'd40;
      progImg[1] = encB(bpcuPkg::opRtd, 5'd16, 5'd3, -10);
      progImg[30] = encB(bpcuPkg::opRtd, 5'd16, 5'd0, 8);
      progImg[8] = {bpcuPkg::opHalt, 26'd0};
      loadProgram();
      loadRegs();
      startRun();
      finishRun();

      // Test 5 runs random branch programs
      testName = "randomProgram";
      for (int p = 0; p < 10; p++) begin
         tries = 0;
         do begin
            for (int a = 0; a < 31; a++) begin
               case ($urandom_range(0, 9))
                  0: progImg[a] = encA(bpcuPkg::opBr, 5'd0, 5'($urandom_range(0, 31)),
                                       5'($urandom_range(1, 7)));
                  1: progImg[a] = encB(bpcuPkg::opBrI, 5'd0, 5'($urandom_range(0, 31)),
                                       int'($urandom_range(0, 16)) - 8);
                  2: progImg[a] = encA(bpcuPkg::opBcc, 5'($urandom_range(0, 31)),
                                       5'($urandom_range(0, 7)), 5'($urandom_range(1, 7)));
                  3: progImg[a] = encB(bpcuPkg::opBccI, 5'($urandom_range(0, 31)),
                                       5'($urandom_range(0, 7)), int'($urandom_range(0, 16)) - 8);
                  4: progImg[a] = encB(bpcuPkg::opRtd, 5'd16, 5'($urandom_range(0, 7)),
                                       int'($urandom_range(0, 31)));
                  default: progImg[a] = {6'($urandom_range(0, 31)), 26'($urandom)};
               endcase
            end
            progImg[31] = {bpcuPkg::opHalt, 26'd0};
            for (int r = 1; r < 8; r++) begin
               regImg[r] = randVal();
            end
            tries++;
         end while (!refRun(progImg, regImg) && tries < 20);
         // A program that is still endless falls through to the final HALT
         if (tries >= 20 && !refRun(progImg, regImg)) begin
            clearProgram();
            progImg[31] = {bpcuPkg::opHalt, 26'd0};
         end
         loadProgram();
         loadRegs();
         startRun();
         finishRun();
      end

      // Test 6 locks the host port while running and replays on restart
      testName = "lockRestart";
      buildJumpProgram();
      loadProgram();
      loadRegs();
      startRun();
      // A HALT at word 0 would cut the replay short if the write got through
      apbWrite(bpcuPkg::addrMemBase, {bpcuPkg::opHalt, 26'd0}, 1'b1);
      apbWrite(bpcuPkg::addrRegBase + 16'd4, 32'h55, 1'b1);
      finishRun();
      readCheck(bpcuPkg::addrRegBase + 16'd4, regImg[1]);
      startRun();
      finishRun();

      $display("checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
bpcuPkg.sv
progMem.sv
regFile.sv
hostPort.sv
fetchDecode.sv
branchPcUnit.sv
bpcuTop.sv
bpcu_properties.sv
bpcuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bpcuTb -f sources.f -o bpcuSim \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/bpcuSim > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
